// ==== compile.f ====
common/camera_pkg.sv
image_gen/image_gen.sv
logic/raw10_packer.sv
logic/csi2_packet_framer.sv
logic/credit_tx_port.sv
logic/camera_tx_top.sv
dv/camera_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the camera transmit testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module camera_tx_tb \
    -Mdir obj_dir -o camera_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/camera_tx_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== dv/camera_tx_tb.sv ====
// Testbench for the camera transmit path with a credit-returning random
// sink, a byte-level reference of two CSI-2 frames and credit limit checks.
// A 200-cycle stall mid-frame checks that back-pressure loses no bytes.
module camera_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import camera_pkg::*;

    localparam int HPIX         = 16;
    localparam int VPIX         = 4;
    localparam int CREDITS_INIT = 4;
    localparam int FRAMES       = 2;
    localparam int STALL_AT     = 40;     // inside the second line packet
    localparam int TIMEOUT      = 20000;
    localparam logic [5:0] ECC_COLUMN [24] = '{
        6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
        6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
        6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B};

    logic      clock_camera_byte   = 1'b0;
    logic      reset_camera_byte_n = 1'b0;
    logic      credit_return       = 1'b0;
    csi_byte_t tx;
    logic      tx_valid;

    csi_byte_t   exp_q[$];
    logic [7:0]  sink_q[$];
    int          rx_count   = 0;
    int          ret_count  = 0;
    int          pkt_num    = 0;
    int          pkt_pos    = 0;
    logic        stalling   = 1'b0;
    logic        stall_full = 1'b0;
    logic [15:0] lfsr       = 16'd67;
    logic        drain;

    camera_tx_top #(
        .HPIX(HPIX), .VPIX(VPIX), .HBLANK(6), .VBLANK(1), .CREDITS_INIT(CREDITS_INIT)
    ) camera_tx_top_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .tx_o                (tx),
        .tx_valid_o          (tx_valid),
        .credit_return_i     (credit_return)
    );

    initial begin
        forever #5 clock_camera_byte = ~clock_camera_byte;
    end

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        stop_on_failure($sformatf("FAIL t=%0t %s", $time, what));
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [5:0] header_ecc(input logic [23:0] d);
        logic [5:0] ecc;
        ecc = '0;
        for (int i = 0; i < 24; i++)
            if (d[i]) ecc ^= ECC_COLUMN[i];   // syndrome column of bit i
        return ecc;
    endfunction

    function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc ^ {8'h00, b};
        for (int i = 0; i < 8; i++)
            c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
        return c;
    endfunction

    // bayer site and colour bar of one active pixel
    function automatic logic [9:0] bar_pixel(input int row, input int col);
        logic red;
        logic green;
        logic blue;
        int   bar;
        bar   = col * 4 / HPIX;
        red   = (row % 2 == 1) && (col % 2 == 1);
        blue  = (row % 2 == 0) && (col % 2 == 0);
        green = !red && !blue;
        case (bar)
            0:       return 10'h3FF;
            1:       return (red || blue) ? 10'h3FF : 10'h000;
            2:       return green ? 10'h3FF : 10'h000;
            default: return (red || green) ? 10'h3FF : 10'h000;
        endcase
    endfunction

    task automatic push_byte(input logic [7:0] d, input logic sop, input logic eop);
        csi_byte_t b;
        b.data = d;
        b.sop  = sop;
        b.eop  = eop;
        exp_q.push_back(b);
    endtask

    task automatic push_header(input logic [5:0] dt, input logic [15:0] wc, input logic short_pkt);
        push_byte({2'b00, dt}, 1'b1, 1'b0);
        push_byte(wc[7:0], 1'b0, 1'b0);
        push_byte(wc[15:8], 1'b0, 1'b0);
        push_byte({2'b00, header_ecc({wc, 2'b00, dt})}, 1'b0, short_pkt);
    endtask

    task automatic push_line(input int row);
        logic [15:0] crc;
        logic [9:0]  p [4];
        crc = 16'hFFFF;
        push_header(DT_RAW10, 16'(HPIX * 10 / 8), 1'b0);
        for (int g = 0; g < HPIX / 4; g++) begin
            for (int k = 0; k < 4; k++) begin
                p[k] = bar_pixel(row, g * 4 + k);
                push_byte(p[k][9:2], 1'b0, 1'b0);
                crc = crc16_update(crc, p[k][9:2]);
            end
            push_byte({p[3][1:0], p[2][1:0], p[1][1:0], p[0][1:0]}, 1'b0, 1'b0);
            crc = crc16_update(crc, {p[3][1:0], p[2][1:0], p[1][1:0], p[0][1:0]});
        end
        push_byte(crc[7:0], 1'b0, 1'b0);    // low footer byte first
        push_byte(crc[15:8], 1'b0, 1'b1);
    endtask

    task automatic check_byte(input csi_byte_t got);
        csi_byte_t exp;
        exp = exp_q.pop_front();
        a_byte: assert (got == exp) else report_mismatch($sformatf(
            "packet %0d byte %0d: got %h sop %b eop %b, expected %h sop %b eop %b",
            pkt_num, pkt_pos, got.data, got.sop, got.eop, exp.data, exp.sop, exp.eop));
        pkt_pos++;
        if (got.eop) begin
            pkt_num++;
            pkt_pos = 0;
        end
    endtask

    // sink samples on the falling edge and returns one credit per drained byte
    always @(negedge clock_camera_byte) begin
        if (!reset_camera_byte_n) begin
            credit_return = 1'b0;
        end else begin
            if (tx_valid && exp_q.size() != 0) begin
                check_byte(tx);
                sink_q.push_back(tx.data);
                rx_count++;
                a_sink_room: assert (sink_q.size() <= CREDITS_INIT)
                    else report_mismatch("sink holds more bytes than the credit limit");
            end
            if (stalling && (rx_count - ret_count == CREDITS_INIT))
                stall_full = 1'b1;
            if (stalling) begin
                credit_return = 1'b0;
            end else begin
                drain = lfsr[0];
                lfsr  = lfsr_step(lfsr);
                if (drain && sink_q.size() != 0) begin
                    void'(sink_q.pop_front());
                    ret_count++;
                    credit_return = 1'b1;
                end else begin
                    credit_return = 1'b0;
                end
            end
        end
    end

    a_outstanding: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        rx_count - ret_count <= CREDITS_INIT
    ) else report_mismatch("bytes outstanding exceed the credit limit");

    a_stall_quiet: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        stalling && stall_full |=> !tx_valid
    ) else report_mismatch("tx_valid_o high with all credits held by the sink");

    initial begin
        int wait_cycles;
        for (int f = 0; f < FRAMES; f++) begin
            push_header(DT_FS, 16'(f), 1'b1);
            for (int r = 0; r < VPIX; r++)
                push_line(r);
            push_header(DT_FE, 16'(f), 1'b1);
        end
        repeat (3) @(posedge clock_camera_byte);
        @(negedge clock_camera_byte);
        reset_camera_byte_n <= 1'b1;

        wait_cycles = 0;
        while (rx_count < STALL_AT) begin
            if (wait_cycles == TIMEOUT)
                stop_on_failure("timeout: bytes before the stall never arrived");
            wait_cycles++;
            @(posedge clock_camera_byte);
        end
        stalling = 1'b1;
        repeat (200) @(posedge clock_camera_byte);
        stalling = 1'b0;
        if (!stall_full)
            stop_on_failure("the sink never held all credits during the stall");

        wait_cycles = 0;
        while (exp_q.size() != 0) begin
            if (wait_cycles == TIMEOUT)
                stop_on_failure("timeout: the two frames were not completely received");
            wait_cycles++;
            @(posedge clock_camera_byte);
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== logic/camera_tx_top.sv ====
// Camera byte-clock transmit path top level.
// Colour-bar source, RAW10 packer, CSI-2 framer and credit output port
// chained by valid/ready links. Frame geometry and credits are set here.
module camera_tx_top #(
    parameter int HPIX         = 16,
    parameter int VPIX         = 4,
    parameter int HBLANK       = 6,
    parameter int VBLANK       = 1,
    parameter int CREDITS_INIT = 4
) (
    input  logic                  clock_camera_byte,
    input  logic                  reset_camera_byte_n,
    output camera_pkg::csi_byte_t tx_o,
    output logic                  tx_valid_o,
    input  logic                  credit_return_i
);
    import camera_pkg::*;

    pix_beat_t  pix;
    logic       pix_valid;
    logic       pix_ready;
    byte_beat_t byte_beat;
    logic       byte_valid;
    logic       byte_ready;
    csi_byte_t  pkt;
    logic       pkt_valid;
    logic       pkt_ready;

    image_gen #(
        .HPIX   (HPIX),
        .VPIX   (VPIX),
        .HBLANK (HBLANK),
        .VBLANK (VBLANK)
    ) image_gen_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pix_o               (pix),
        .pix_valid_o         (pix_valid),
        .pix_ready_i         (pix_ready)
    );

    raw10_packer raw10_packer_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pix_i               (pix),
        .pix_valid_i         (pix_valid),
        .pix_ready_o         (pix_ready),
        .byte_o              (byte_beat),
        .byte_valid_o        (byte_valid),
        .byte_ready_i        (byte_ready)
    );

    csi2_packet_framer #(
        .HPIX (HPIX)
    ) csi2_packet_framer_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .byte_i              (byte_beat),
        .byte_valid_i        (byte_valid),
        .byte_ready_o        (byte_ready),
        .pkt_o               (pkt),
        .pkt_valid_o         (pkt_valid),
        .pkt_ready_i         (pkt_ready)
    );

    credit_tx_port #(
        .CREDITS_INIT (CREDITS_INIT)
    ) credit_tx_port_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pkt_i               (pkt),
        .pkt_valid_i         (pkt_valid),
        .pkt_ready_o         (pkt_ready),
        .tx_o                (tx_o),
        .tx_valid_o          (tx_valid_o),
        .credit_return_i     (credit_return_i)
    );

endmodule

// ==== logic/credit_tx_port.sv ====
// Credit-based output port toward the downstream consumer.
// Registers each accepted byte and spends one credit per byte; the
// consumer returns credits with one-cycle pulses on credit_return_i.
module credit_tx_port #(
    parameter int CREDITS_INIT = 4
) (
    input  logic                  clock_camera_byte,
    input  logic                  reset_camera_byte_n,
    input  camera_pkg::csi_byte_t pkt_i,
    input  logic                  pkt_valid_i,
    output logic                  pkt_ready_o,
    output camera_pkg::csi_byte_t tx_o,
    output logic                  tx_valid_o,
    input  logic                  credit_return_i
);
    localparam int CW = $clog2(CREDITS_INIT + 1);

    logic [CW-1:0] credits;
    logic          send;

    assign pkt_ready_o = (credits != '0);
    assign send        = pkt_valid_i && pkt_ready_o;

    always_ff @(posedge clock_camera_byte) begin
        if (send)
            tx_o <= pkt_i;
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            credits    <= CW'(CREDITS_INIT);
            tx_valid_o <= 1'b0;
        end else begin
            tx_valid_o <= send;
            case ({send, credit_return_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;     // none, or send and return
            endcase
        end
    end

    // consumer must not return more than it was given
    a_credit_max: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        credits <= CW'(CREDITS_INIT)
    );

    a_credit_min: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        tx_valid_o |-> $past(credits) != '0
    );

endmodule

// ==== logic/csi2_packet_framer.sv ====
// CSI-2 packet framer on virtual channel 0.
// FS/FE beats become 4-byte short packets carrying the frame number. Each
// line becomes a long packet: header with ECC, RAW10 payload, CRC-16 footer.
module csi2_packet_framer #(
    parameter int HPIX = 16
) (
    input  logic                   clock_camera_byte,
    input  logic                   reset_camera_byte_n,
    input  camera_pkg::byte_beat_t byte_i,
    input  logic                   byte_valid_i,
    output logic                   byte_ready_o,
    output camera_pkg::csi_byte_t  pkt_o,
    output logic                   pkt_valid_o,
    input  logic                   pkt_ready_i
);
    import camera_pkg::*;

    localparam logic [15:0] WC = 16'(HPIX * 10 / 8);

    typedef enum logic [1:0] {IDLE, HDR, PAYLOAD, CRC} state_e;

    state_e      state;
    logic [1:0]  hdr_idx;
    logic        crc_idx;
    logic [15:0] pay_cnt;
    logic [15:0] frame_cnt;
    logic [15:0] crc_q;
    logic [15:0] wc_q;
    logic [5:0]  dt_q;
    logic        short_q;
    logic        fe_q;
    logic [5:0]  ecc;
    logic        pay_xfer;

    // reflected 0x1021, lsb first
    function automatic logic [15:0] crc16_byte(input logic [15:0] crc_in,
                                               input logic [7:0]  data);
        logic [15:0] crc;
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ data[i])
                crc = (crc >> 1) ^ 16'h8408;
            else
                crc = crc >> 1;
        end
        return crc;
    endfunction

    assign ecc      = csi2_ecc({wc_q, 2'b00, dt_q});
    assign pay_xfer = (state == PAYLOAD) && byte_valid_i && pkt_ready_i;

    always_comb begin
        pkt_o        = '0;
        pkt_valid_o  = 1'b0;
        byte_ready_o = 1'b0;
        case (state)
            IDLE: byte_ready_o = byte_valid_i && byte_i.kind != BEAT_PIXEL;
            HDR: begin
                pkt_valid_o = 1'b1;
                pkt_o.sop   = (hdr_idx == 2'd0);
                pkt_o.eop   = short_q && (hdr_idx == 2'd3);
                case (hdr_idx)
                    2'd0:    pkt_o.data = {2'b00, dt_q};   // DI, vc 0
                    2'd1:    pkt_o.data = wc_q[7:0];
                    2'd2:    pkt_o.data = wc_q[15:8];
                    default: pkt_o.data = {2'b00, ecc};
                endcase
            end
            PAYLOAD: begin
                pkt_valid_o  = byte_valid_i;
                byte_ready_o = pkt_ready_i;
                pkt_o.data   = byte_i.data;
            end
            default: begin
                pkt_valid_o = 1'b1;
                pkt_o.data  = crc_idx ? crc_q[15:8] : crc_q[7:0];
                pkt_o.eop   = crc_idx;
            end
        endcase
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state     <= IDLE;
            hdr_idx   <= '0;
            crc_idx   <= 1'b0;
            pay_cnt   <= '0;
            frame_cnt <= '0;
            crc_q     <= 16'hFFFF;
            wc_q      <= '0;
            dt_q      <= DT_FS;
            short_q   <= 1'b0;
            fe_q      <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    hdr_idx <= '0;
                    if (byte_valid_i && byte_i.kind != BEAT_PIXEL) begin
                        short_q <= 1'b1;
                        fe_q    <= (byte_i.kind == BEAT_FE);
                        dt_q    <= (byte_i.kind == BEAT_FE) ? DT_FE : DT_FS;
                        wc_q    <= frame_cnt;
                        state   <= HDR;
                    end else if (byte_valid_i && byte_i.line_first) begin
                        short_q <= 1'b0;           // line byte stays for PAYLOAD
                        dt_q    <= DT_RAW10;
                        wc_q    <= WC;
                        state   <= HDR;
                    end
                end
                HDR: if (pkt_ready_i) begin
                    hdr_idx <= hdr_idx + 1'b1;
                    if (hdr_idx == 2'd3) begin
                        pay_cnt <= '0;
                        crc_q   <= 16'hFFFF;       // seed
                        state   <= short_q ? IDLE : PAYLOAD;
                        if (short_q && fe_q)
                            frame_cnt <= frame_cnt + 1'b1;
                    end
                end
                PAYLOAD: if (pay_xfer) begin
                    crc_q   <= crc16_byte(crc_q, byte_i.data);
                    pay_cnt <= pay_cnt + 1'b1;
                    if (pay_cnt == WC - 1'b1) begin
                        crc_idx <= 1'b0;
                        state   <= CRC;
                    end
                end
                default: if (pkt_ready_i) begin
                    crc_idx <= 1'b1;
                    if (crc_idx)
                        state <= IDLE;
                end
            endcase
        end
    end

    // packer line end must land on the last counted payload byte
    a_line_end: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        pay_xfer && pay_cnt == WC - 1'b1 |-> byte_i.line_last
    );

endmodule

// ==== logic/raw10_packer.sv ====
// RAW10 packer: four 10-bit pixels in, five bytes out.
// Bytes 0..3 are the upper 8 bits of each pixel, byte 4 holds the low bit
// pairs (pixel 0 in bits 1:0). FS and FE pass through as single beats.
module raw10_packer (
    input  logic                  clock_camera_byte,
    input  logic                  reset_camera_byte_n,
    input  camera_pkg::pix_beat_t pix_i,
    input  logic                  pix_valid_i,
    output logic                  pix_ready_o,
    output camera_pkg::byte_beat_t byte_o,
    output logic                  byte_valid_o,
    input  logic                  byte_ready_i
);
    import camera_pkg::*;

    logic [7:0]  hi_q [4];
    logic [7:0]  lo_q;
    logic        first_q;
    logic        last_q;
    beat_kind_e  kind_q;
    logic [1:0]  cnt;       // pixels gathered in current group
    logic [2:0]  idx;       // byte being emitted
    logic        emit;
    logic        take;
    logic        last_byte;

    assign pix_ready_o  = !emit;
    assign take         = pix_valid_i && pix_ready_o;
    assign byte_valid_o = emit;
    assign last_byte    = (kind_q == BEAT_PIXEL) ? (idx == 3'd4) : 1'b1;

    always_comb begin
        byte_o.kind       = kind_q;
        byte_o.line_first = (kind_q == BEAT_PIXEL) && first_q && (idx == 3'd0);
        byte_o.line_last  = (kind_q == BEAT_PIXEL) && last_q && (idx == 3'd4);
        if (kind_q != BEAT_PIXEL)
            byte_o.data = 8'h00;
        else if (idx == 3'd4)
            byte_o.data = lo_q;
        else
            byte_o.data = hi_q[idx[1:0]];
    end

    // pixel payload
    always_ff @(posedge clock_camera_byte) begin
        if (take && pix_i.kind == BEAT_PIXEL) begin
            hi_q[cnt]            <= pix_i.data[9:2];
            lo_q[{cnt, 1'b0} +: 2] <= pix_i.data[1:0];
            if (cnt == 2'd0)
                first_q <= pix_i.line_first;
            if (cnt == 2'd3)
                last_q <= pix_i.line_last;
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            cnt    <= '0;
            idx    <= '0;
            emit   <= 1'b0;
            kind_q <= BEAT_PIXEL;
        end else if (take) begin
            idx <= '0;
            if (pix_i.kind != BEAT_PIXEL) begin
                kind_q <= pix_i.kind;
                emit   <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
                if (cnt == 2'd3) begin
                    kind_q <= BEAT_PIXEL;
                    emit   <= 1'b1;
                end
            end
        end else if (emit && byte_ready_i) begin
            if (last_byte)
                emit <= 1'b0;
            else
                idx <= idx + 1'b1;
        end
    end

    // frame markers only between groups, lines are a multiple of 4 wide
    a_marker_aligned: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        pix_valid_i && pix_i.kind != BEAT_PIXEL |-> cnt == 2'd0
    );

endmodule

// ==== image_gen/image_gen.sv ====
// Bayer RAW10 colour-bar test frame source with FS/FE markers.
// Walks x/y slot counters through blanking, FS, active lines and FE.
// Slots holding a beat wait for pix_ready_i; idle slots pass one per cycle.
module image_gen #(
    parameter int HPIX   = 16,
    parameter int VPIX   = 4,
    parameter int HBLANK = 6,
    parameter int VBLANK = 1
) (
    input  logic                 clock_camera_byte,
    input  logic                 reset_camera_byte_n,
    output camera_pkg::pix_beat_t pix_o,
    output logic                 pix_valid_o,
    input  logic                 pix_ready_i
);
    import camera_pkg::*;

    localparam int LINE   = HPIX + HBLANK;
    localparam int ROWS   = VBLANK + VPIX + 2;     // blank lines, FS, active, FE
    localparam int XW     = $clog2(LINE + 1);
    localparam int YW     = $clog2(ROWS + 1);
    localparam int FS_ROW = VBLANK;
    localparam int FE_ROW = VBLANK + VPIX + 1;

    logic [XW-1:0] x;
    logic [YW-1:0] y;
    logic [YW-1:0] row;       // active line index
    logic [1:0]    bar;
    logic          active;
    logic          marker;    // FS or FE slot
    logic          step;
    logic          is_green;
    logic          is_blue;
    logic [9:0]    colour;

    assign active = (y > YW'(FS_ROW)) && (y < YW'(FE_ROW)) && (x < XW'(HPIX));
    assign marker = ((y == YW'(FS_ROW)) || (y == YW'(FE_ROW))) && (x == '0);
    assign row    = y - YW'(FS_ROW + 1);
    assign bar    = 2'((32'(x) * 4) / HPIX);

    // odd row: odd x red, even x green. even row: odd x green, even x blue
    assign is_green = row[0] ^ x[0];
    assign is_blue  = !row[0] && !x[0];

    always_comb begin
        case (bar)
            2'd0:    colour = 10'h3FF;                      // white
            2'd1:    colour = is_green ? 10'h000 : 10'h3FF; // magenta
            2'd2:    colour = is_green ? 10'h3FF : 10'h000; // green
            default: colour = is_blue ? 10'h000 : 10'h3FF;  // yellow
        endcase
    end

    always_comb begin
        pix_valid_o      = active || marker;
        pix_o.kind       = BEAT_PIXEL;
        pix_o.line_first = active && (x == '0);
        pix_o.line_last  = active && (x == XW'(HPIX - 1));
        pix_o.data       = active ? colour : 10'h000;
        if (marker) begin
            pix_o.kind = (y == YW'(FS_ROW)) ? BEAT_FS : BEAT_FE;
        end
    end

    // beats wait for the packer, blanking runs free
    assign step = pix_valid_o ? pix_ready_i : 1'b1;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            x <= '0;
            y <= '0;
        end else if (step) begin
            if (x == XW'(LINE - 1)) begin
                x <= '0;
                y <= (y == YW'(ROWS - 1)) ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    a_pix_hold: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        pix_valid_o && !pix_ready_i |=> pix_valid_o && $stable(pix_o)
    );

endmodule

// ==== common/camera_pkg.sv ====
// Shared types for the camera byte-clock transmit path.
// Beat structs for the generator, packer and framer links, CSI-2 data types
// and the packet header ECC. Modules import this where they need it.
package camera_pkg;

    typedef enum logic [1:0] {
        BEAT_FS,
        BEAT_PIXEL,
        BEAT_FE
    } beat_kind_e;

    typedef struct packed {
        beat_kind_e  kind;
        logic        line_first;
        logic        line_last;
        logic [9:0]  data;
    } pix_beat_t;

    typedef struct packed {
        beat_kind_e  kind;
        logic        line_first;
        logic        line_last;
        logic [7:0]  data;
    } byte_beat_t;

    typedef struct packed {
        logic [7:0]  data;
        logic        sop;   // first byte of a packet
        logic        eop;   // last byte of a packet
    } csi_byte_t;

    localparam logic [5:0] DT_FS    = 6'h00;
    localparam logic [5:0] DT_FE    = 6'h01;
    localparam logic [5:0] DT_RAW10 = 6'h2B;

    // hamming ECC over {wc_hi, wc_lo, di}
    function automatic logic [5:0] csi2_ecc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
             ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
             ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
             ^ d[18] ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
             ^ d[19] ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
             ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

endpackage
